//--- flist.f
src/axi_lite_pkg.sv
src/regfile_pkg.sv
src/axi_lite_master.sv
src/axi_lite_regfile.sv
src/axi_lite_subsys.sv
dv/tb_axi_lite_subsys.sv

//--- Bender.yml
package:
  name: axi_lite_subsys

sources:
  # Packages first, then RTL in dependency order
  - files:
      - src/axi_lite_pkg.sv
      - src/regfile_pkg.sv
      - src/axi_lite_master.sv
      - src/axi_lite_regfile.sv
      - src/axi_lite_subsys.sv

  - target: test
    files:
      - dv/tb_axi_lite_subsys.sv

//--- dv/tb_axi_lite_subsys.sv
`timescale 1ns/10ps

module tb_axi_lite_subsys;

    import axi_lite_pkg::*;
    import regfile_pkg::*;

    localparam int SEED     = 34;
    localparam int N_WRITES = 24;
    localparam int N_MIX    = 60;
    // Directed reads and writes stay under 50
    localparam int NUM_TRANS      = 2 * N_WRITES + N_MIX + 50;
    localparam int TIMEOUT_CYCLES = NUM_TRANS * 12 + 50;

    logic                  clk;
    logic                  rst_n;
    logic                  write_req;
    logic [ADDR_WIDTH-1:0] write_addr;
    logic [DATA_WIDTH-1:0] write_data;
    logic [STRB_WIDTH-1:0] write_strb;
    logic                  write_done;
    logic [RESP_WIDTH-1:0] write_resp;
    logic                  read_req;
    logic [ADDR_WIDTH-1:0] read_addr;
    logic [DATA_WIDTH-1:0] read_data;
    logic [RESP_WIDTH-1:0] read_resp;
    logic                  read_done;
    logic                  busy;

    // Reference copy of the register map
    logic [DATA_WIDTH-1:0] model_regs [NUM_REGS];
    int unsigned           model_count;

    string       cur_test;
    int          test_errors;
    int          total_errors;
    int          tests_passed;
    int          tests_failed;
    int          cycle_count;

    axi_lite_subsys axi_lite_subsys_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .write_req  (write_req),
        .write_addr (write_addr),
        .write_data (write_data),
        .write_strb (write_strb),
        .write_done (write_done),
        .write_resp (write_resp),
        .read_req   (read_req),
        .read_addr  (read_addr),
        .read_data  (read_data),
        .read_resp  (read_resp),
        .read_done  (read_done),
        .busy       (busy)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test FAILED");
            $finish;
        end else begin
            cycle_count <= cycle_count + 1;
        end
    end

    function automatic logic [ADDR_WIDTH-1:0] word_addr(input int idx);
        logic [ADDR_WIDTH-1:0] a;
        a = idx;
        return a << 2;
    endfunction

    // Random word-aligned address with a bit set above the 32-byte map
    function automatic logic [ADDR_WIDTH-1:0] past_map_addr();
        logic [ADDR_WIDTH-1:0] a;
        a = $urandom | (NUM_REGS * 4);
        a[1:0] = 2'b00;
        return a;
    endfunction

    function automatic bit addr_in_map(input logic [ADDR_WIDTH-1:0] a);
        return (a / (NUM_REGS * 4)) == 0;
    endfunction

    function automatic int addr_index(input logic [ADDR_WIDTH-1:0] a);
        return (a / 4) % NUM_REGS;
    endfunction

    function automatic void model_write(input logic [ADDR_WIDTH-1:0] addr,
                                        input logic [DATA_WIDTH-1:0] data,
                                        input logic [STRB_WIDTH-1:0] strb,
                                        output logic [RESP_WIDTH-1:0] resp);
        int idx;
        idx = addr_index(addr);
        if (!addr_in_map(addr) || idx == REG_ID || idx == REG_WCOUNT) begin
            resp = RESP_SLVERR;
        end else begin
            for (int b = 0; b < STRB_WIDTH; b++) begin
                if (strb[b]) begin
                    model_regs[idx][8*b +: 8] = data[8*b +: 8];
                end
            end
            model_count++;
            resp = RESP_OKAY;
        end
    endfunction

    function automatic void model_read(input logic [ADDR_WIDTH-1:0] addr,
                                       output logic [DATA_WIDTH-1:0] data,
                                       output logic [RESP_WIDTH-1:0] resp);
        int idx;
        idx  = addr_index(addr);
        resp = RESP_OKAY;
        if (!addr_in_map(addr)) begin
            data = '0;
            resp = RESP_SLVERR;
        end else if (idx == REG_ID) begin
            data = ID_VALUE;
        end else if (idx == REG_WCOUNT) begin
            data = model_count;
        end else begin
            data = model_regs[idx];
        end
    endfunction

    task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp)
        else begin
            $display("Mismatch %s %s: expected %h actual %h", cur_test, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_true(input bit cond, input string msg);
        assert (cond)
        else begin
            $display("Error in %s: %s", cur_test, msg);
            test_errors++;
        end
    endtask

    // Wait on the done pulse while the other done stays quiet
    task automatic wait_for_done(input bit is_write);
        bit seen;
        seen = 1'b0;
        while (!seen) begin
            @(negedge clk);
            if (is_write) begin
                check_true(!read_done, "read_done pulsed during a write");
                seen = write_done;
            end else begin
                check_true(!write_done, "write_done pulsed during a read");
                seen = read_done;
            end
        end
        check_true(!busy, "busy still high after the done pulse");
    endtask

    task automatic do_write(input logic [ADDR_WIDTH-1:0] addr,
                            input logic [DATA_WIDTH-1:0] data,
                            input logic [STRB_WIDTH-1:0] strb);
        logic [RESP_WIDTH-1:0] exp_resp;
        check_true(!busy, "busy high when a write was issued");
        write_req  = 1'b1;
        write_addr = addr;
        write_data = data;
        write_strb = strb;
        @(negedge clk);
        write_req = 1'b0;
        wait_for_done(1'b1);
        model_write(addr, data, strb, exp_resp);
        check_value("write_resp", exp_resp, write_resp);
    endtask

    task automatic do_read(input logic [ADDR_WIDTH-1:0] addr);
        logic [DATA_WIDTH-1:0] exp_data;
        logic [RESP_WIDTH-1:0] exp_resp;
        check_true(!busy, "busy high when a read was issued");
        read_req  = 1'b1;
        read_addr = addr;
        @(negedge clk);
        read_req = 1'b0;
        wait_for_done(1'b0);
        model_read(addr, exp_data, exp_resp);
        check_value("read_resp", exp_resp, read_resp);
        check_value("read_data", exp_data, read_data);
    endtask

    task automatic verify_map();
        for (int i = 0; i < NUM_REGS; i++) begin
            do_read(word_addr(i));
        end
    endtask

    task automatic start_test(input string name);
        cur_test    = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        if (test_errors == 0) begin
            tests_passed++;
            $display("%s: passed", cur_test);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", cur_test, test_errors);
        end
        total_errors += test_errors;
    endtask

    initial begin
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] data;
        logic [RESP_WIDTH-1:0] exp_resp;
        int                    idx;

        clk          = 1'b0;
        rst_n        = 1'b0;
        write_req    = 1'b0;
        write_addr   = '0;
        write_data   = '0;
        write_strb   = '0;
        read_req     = 1'b0;
        read_addr    = '0;
        cycle_count  = 0;
        total_errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        model_count  = 0;
        void'($urandom(SEED));
        for (int i = 0; i < NUM_REGS; i++) begin
            model_regs[i] = '0;
        end

        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        start_test("reset_idle");
        repeat (5) begin
            @(negedge clk);
            check_true(!busy && !write_done && !read_done, "busy or a done output high while idle");
        end
        do_read(word_addr(REG_ID));
        end_test();

        start_test("random_rw");
        for (int n = 0; n < N_WRITES; n++) begin
            idx  = $urandom_range(1, NUM_REGS - 2);
            addr = word_addr(idx);
            do_write(addr, $urandom, $urandom_range(1, 15));
            do_read(addr);
        end
        for (int i = 1; i < NUM_REGS - 1; i++) begin
            do_read(word_addr(i));
        end
        end_test();

        start_test("readonly_writes");
        do_write(word_addr(REG_ID), $urandom, 4'hF);
        do_write(word_addr(REG_WCOUNT), $urandom, 4'hF);
        repeat (4) begin
            do_write(past_map_addr(), $urandom, 4'hF);
        end
        verify_map();
        end_test();

        start_test("past_map_reads");
        repeat (4) begin
            do_read(past_map_addr());
        end
        do_read(word_addr(REG_WCOUNT));
        end_test();

        start_test("collision");
        addr = word_addr(2);
        data = $urandom;
        write_req  = 1'b1;
        write_addr = addr;
        write_data = data;
        write_strb = 4'hF;
        read_req   = 1'b1;
        read_addr  = word_addr(REG_WCOUNT);
        @(negedge clk);
        write_req = 1'b0;
        read_req  = 1'b0;
        check_true(busy, "collision request was not accepted");
        // Second pair of strobes lands while the write is in flight
        write_req  = 1'b1;
        write_addr = word_addr(3);
        write_data = ~data;
        read_req   = 1'b1;
        read_addr  = word_addr(1);
        @(negedge clk);
        write_req = 1'b0;
        // Lone read strobe while still busy
        read_addr = word_addr(REG_ID);
        @(negedge clk);
        read_req = 1'b0;
        wait_for_done(1'b1);
        model_write(addr, data, 4'hF, exp_resp);
        check_value("write_resp", exp_resp, write_resp);
        repeat (3) begin
            @(negedge clk);
            check_true(!busy && !write_done && !read_done, "activity after the collision write");
        end
        verify_map();
        end_test();

        start_test("random_mix");
        for (int n = 0; n < N_MIX; n++) begin
            if ($urandom_range(0, 7) == 0) begin
                addr = past_map_addr();
            end else begin
                addr = word_addr($urandom_range(0, NUM_REGS - 1));
            end
            if ($urandom_range(0, 1) == 1) begin
                do_write(addr, $urandom, $urandom_range(0, 15));
            end else begin
                do_read(addr);
            end
        end
        verify_map();
        end_test();

        $display("Summary: %0d tests passed, %0d tests failed, %0d check errors",
                 tests_passed, tests_failed, total_errors);
        if (total_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- src/axi_lite_subsys.sv
`timescale 1ns/10ps

module axi_lite_subsys (
    input  logic                                clk,
    input  logic                                rst_n,

    input  logic                                write_req,
    input  logic [axi_lite_pkg::ADDR_WIDTH-1:0] write_addr,
    input  logic [axi_lite_pkg::DATA_WIDTH-1:0] write_data,
    input  logic [axi_lite_pkg::STRB_WIDTH-1:0] write_strb,
    output logic                                write_done,
    output logic [axi_lite_pkg::RESP_WIDTH-1:0] write_resp,

    input  logic                                read_req,
    input  logic [axi_lite_pkg::ADDR_WIDTH-1:0] read_addr,
    output logic [axi_lite_pkg::DATA_WIDTH-1:0] read_data,
    output logic [axi_lite_pkg::RESP_WIDTH-1:0] read_resp,
    output logic                                read_done,

    output logic                                busy
);

    import axi_lite_pkg::*;

    // AXI-Lite wires between master and register file
    logic [ADDR_WIDTH-1:0] awaddr;
    logic                  awvalid;
    logic                  awready;
    logic [DATA_WIDTH-1:0] wdata;
    logic [STRB_WIDTH-1:0] wstrb;
    logic                  wvalid;
    logic                  wready;
    logic [RESP_WIDTH-1:0] bresp;
    logic                  bvalid;
    logic                  bready;
    logic [ADDR_WIDTH-1:0] araddr;
    logic                  arvalid;
    logic                  arready;
    logic [DATA_WIDTH-1:0] rdata;
    logic [RESP_WIDTH-1:0] rresp;
    logic                  rvalid;
    logic                  rready;

    axi_lite_master axi_lite_master_i (
        .*
    );

    axi_lite_regfile axi_lite_regfile_i (
        .*
    );

endmodule

//--- src/axi_lite_regfile.sv
`timescale 1ns/10ps

module axi_lite_regfile (
    input  logic                                clk,
    input  logic                                rst_n,

    input  logic [axi_lite_pkg::ADDR_WIDTH-1:0] awaddr,
    input  logic                                awvalid,
    output logic                                awready,

    input  logic [axi_lite_pkg::DATA_WIDTH-1:0] wdata,
    input  logic [axi_lite_pkg::STRB_WIDTH-1:0] wstrb,
    input  logic                                wvalid,
    output logic                                wready,

    output logic [axi_lite_pkg::RESP_WIDTH-1:0] bresp,
    output logic                                bvalid,
    input  logic                                bready,

    input  logic [axi_lite_pkg::ADDR_WIDTH-1:0] araddr,
    input  logic                                arvalid,
    output logic                                arready,

    output logic [axi_lite_pkg::DATA_WIDTH-1:0] rdata,
    output logic [axi_lite_pkg::RESP_WIDTH-1:0] rresp,
    output logic                                rvalid,
    input  logic                                rready
);

    import axi_lite_pkg::*;
    import regfile_pkg::*;

    logic [DATA_WIDTH-1:0]    regs [NUM_REGS];

    logic [ADDR_WIDTH-1:0]    waddr_q;
    logic                     waddr_held;

    logic                     aw_hs;
    logic                     w_hs;
    logic                     ar_hs;

    logic [REG_IDX_WIDTH-1:0] widx;
    logic [REG_IDX_WIDTH-1:0] ridx;
    logic                     w_in_map;
    logic                     r_in_map;
    logic                     w_allowed;
    logic [DATA_WIDTH-1:0]    rd_word;

    assign aw_hs = awvalid && awready;
    assign w_hs  = wvalid && wready;
    assign ar_hs = arvalid && arready;

    // Word index from address bits 4:2 with all higher bits zero
    assign widx     = waddr_q[REG_IDX_WIDTH+1:2];
    assign ridx     = araddr[REG_IDX_WIDTH+1:2];
    assign w_in_map = (waddr_q[ADDR_WIDTH-1:REG_IDX_WIDTH+2] == '0);
    assign r_in_map = (araddr[ADDR_WIDTH-1:REG_IDX_WIDTH+2] == '0);

    assign w_allowed = w_in_map && (widx != REG_ID) && (widx != REG_WCOUNT);

    // Write address accept
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            awready    <= 1'b0;
            waddr_held <= 1'b0;
        end else begin
            awready <= awvalid && !awready && !waddr_held && !bvalid;
            if (aw_hs) begin
                waddr_held <= 1'b1;
            end else if (w_hs) begin
                waddr_held <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (aw_hs) begin
            waddr_q <= awaddr;
        end
    end

    // Write data accept and response
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wready <= 1'b0;
            bvalid <= 1'b0;
        end else begin
            wready <= wvalid && !wready && waddr_held && !bvalid;
            if (w_hs) begin
                bvalid <= 1'b1;
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (w_hs) begin
            bresp <= w_allowed ? RESP_OKAY : RESP_SLVERR;
        end
    end

    // Word 0 holds the ID and word 7 counts accepted writes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
            regs[REG_ID] <= ID_VALUE;
        end else if (w_hs && w_allowed) begin
            for (int b = 0; b < STRB_WIDTH; b++) begin
                if (wstrb[b]) begin
                    regs[widx][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
            regs[REG_WCOUNT] <= regs[REG_WCOUNT] + 1'b1;
        end
    end

    assign rd_word = r_in_map ? regs[ridx] : '0;

    // Read address accept and data return
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            arready <= arvalid && !arready && !rvalid;
            if (ar_hs) begin
                rvalid <= 1'b1;
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ar_hs) begin
            rdata <= rd_word;
            rresp <= r_in_map ? RESP_OKAY : RESP_SLVERR;
        end
    end

    a_b_held: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid && $stable(bresp));

    a_r_held: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));

endmodule

//--- src/axi_lite_master.sv
`timescale 1ns/10ps

module axi_lite_master (
    input  logic                                clk,
    input  logic                                rst_n,

    output logic [axi_lite_pkg::ADDR_WIDTH-1:0] awaddr,
    output logic                                awvalid,
    input  logic                                awready,

    output logic [axi_lite_pkg::DATA_WIDTH-1:0] wdata,
    output logic [axi_lite_pkg::STRB_WIDTH-1:0] wstrb,
    output logic                                wvalid,
    input  logic                                wready,

    input  logic [axi_lite_pkg::RESP_WIDTH-1:0] bresp,
    input  logic                                bvalid,
    output logic                                bready,

    output logic [axi_lite_pkg::ADDR_WIDTH-1:0] araddr,
    output logic                                arvalid,
    input  logic                                arready,

    input  logic [axi_lite_pkg::DATA_WIDTH-1:0] rdata,
    input  logic [axi_lite_pkg::RESP_WIDTH-1:0] rresp,
    input  logic                                rvalid,
    output logic                                rready,

    input  logic                                write_req,
    input  logic [axi_lite_pkg::ADDR_WIDTH-1:0] write_addr,
    input  logic [axi_lite_pkg::DATA_WIDTH-1:0] write_data,
    input  logic [axi_lite_pkg::STRB_WIDTH-1:0] write_strb,
    output logic                                write_done,
    output logic [axi_lite_pkg::RESP_WIDTH-1:0] write_resp,

    input  logic                                read_req,
    input  logic [axi_lite_pkg::ADDR_WIDTH-1:0] read_addr,
    output logic [axi_lite_pkg::DATA_WIDTH-1:0] read_data,
    output logic [axi_lite_pkg::RESP_WIDTH-1:0] read_resp,
    output logic                                read_done,

    output logic                                busy
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_WADDR,
        ST_WDATA,
        ST_WRESP,
        ST_RADDR,
        ST_RDATA
    } state_t;

    state_t state_q;

    logic start_wr;
    logic start_rd;

    // Write has priority, a read in the same cycle is dropped
    assign start_wr = (state_q == ST_IDLE) && write_req;
    assign start_rd = (state_q == ST_IDLE) && !write_req && read_req;

    assign busy = (state_q != ST_IDLE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= ST_IDLE;
            awvalid    <= 1'b0;
            wvalid     <= 1'b0;
            bready     <= 1'b0;
            arvalid    <= 1'b0;
            rready     <= 1'b0;
            write_done <= 1'b0;
            read_done  <= 1'b0;
        end else begin
            write_done <= 1'b0;
            read_done  <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (start_wr) begin
                        awvalid <= 1'b1;
                        state_q <= ST_WADDR;
                    end else if (start_rd) begin
                        arvalid <= 1'b1;
                        state_q <= ST_RADDR;
                    end
                end
                ST_WADDR: begin
                    if (awvalid && awready) begin
                        awvalid <= 1'b0;
                        wvalid  <= 1'b1;
                        state_q <= ST_WDATA;
                    end
                end
                ST_WDATA: begin
                    if (wvalid && wready) begin
                        wvalid  <= 1'b0;
                        bready  <= 1'b1;
                        state_q <= ST_WRESP;
                    end
                end
                ST_WRESP: begin
                    if (bvalid && bready) begin
                        bready     <= 1'b0;
                        write_done <= 1'b1;
                        state_q    <= ST_IDLE;
                    end
                end
                ST_RADDR: begin
                    if (arvalid && arready) begin
                        arvalid <= 1'b0;
                        rready  <= 1'b1;
                        state_q <= ST_RDATA;
                    end
                end
                ST_RDATA: begin
                    if (rvalid && rready) begin
                        rready    <= 1'b0;
                        read_done <= 1'b1;
                        state_q   <= ST_IDLE;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // Request payload, held until the matching handshake
    always_ff @(posedge clk) begin
        if (start_wr) begin
            awaddr <= write_addr;
            wdata  <= write_data;
            wstrb  <= write_strb;
        end
        if (start_rd) begin
            araddr <= read_addr;
        end
    end

    // Results stay valid after the done pulse
    always_ff @(posedge clk) begin
        if (bvalid && bready) begin
            write_resp <= bresp;
        end
        if (rvalid && rready) begin
            read_data <= rdata;
            read_resp <= rresp;
        end
    end

    a_one_addr_phase: assert property (@(posedge clk) disable iff (!rst_n)
        !(awvalid && arvalid));

    a_aw_held: assert property (@(posedge clk) disable iff (!rst_n)
        awvalid && !awready |=> awvalid && $stable(awaddr));

    a_w_held: assert property (@(posedge clk) disable iff (!rst_n)
        wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb));

endmodule

//--- src/regfile_pkg.sv
package regfile_pkg;

    // Word map of the register file
    localparam int NUM_REGS      = 8;
    localparam int REG_IDX_WIDTH = $clog2(NUM_REGS);

    // Read-only words
    localparam logic [REG_IDX_WIDTH-1:0] REG_ID     = 3'd0;
    localparam logic [REG_IDX_WIDTH-1:0] REG_WCOUNT = 3'd7;

    // Identification constant returned by word 0
    localparam logic [31:0] ID_VALUE = 32'h5A1E_0100;

endpackage

//--- src/axi_lite_pkg.sv
package axi_lite_pkg;

    // Bus geometry
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    localparam int STRB_WIDTH = DATA_WIDTH / 8;

    // Width of the BRESP and RRESP fields
    localparam int RESP_WIDTH = 2;

    // Response codes, EXOKAY and DECERR never produced here
    localparam logic [RESP_WIDTH-1:0] RESP_OKAY   = 2'b00;
    localparam logic [RESP_WIDTH-1:0] RESP_SLVERR = 2'b10;

endpackage
